// File: common/rv32_pkg.sv
// RV32 ISA definitions for the execute stage and its testbench
// instruction word views and the funct3 codes the datapath decodes
`default_nettype none

package rv32_pkg;

	localparam int XLEN = 32;	// data word width

	////////////////////////////////////////
	// instruction word, one view per format
	////////////////////////////////////////
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i;
		struct packed {
			logic [6:0] imm_hi;	// imm[11:5]
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;	// imm[4:0]
			logic [6:0] opcode;
		} s;
		struct packed {
			logic       imm12;	// sign bit
			logic [5:0] imm10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm4_1;
			logic       imm11;
			logic [6:0] opcode;
		} b;
		struct packed {
			logic [19:0] imm;	// imm[31:12]
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} u;
		struct packed {
			logic       imm20;	// sign bit
			logic [9:0] imm10_1;
			logic       imm11;
			logic [7:0] imm19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j;
	} rv32_inst_t;

	// branch conditions, B-format funct3
	typedef enum logic [2:0] {
		BEQ  = 3'b000,
		BNE  = 3'b001,
		BLT  = 3'b100,
		BGE  = 3'b101,
		BLTU = 3'b110,
		BGEU = 3'b111
	} branch_funct_e;

	// M extension multiplies, R-format funct3
	typedef enum logic [2:0] {
		MUL    = 3'b000,
		MULH   = 3'b001,
		MULHSU = 3'b010,
		MULHU  = 3'b011
	} mult_funct_e;

endpackage

`default_nettype wire

// File: common/ex_pkg.sv
// micro-op encodings used between issue and the execution units
// unit class, ALU function and operand select codes
`default_nettype none

package ex_pkg;

	localparam int TAG_BITS = 6;	// physical tag, 0 = no destination

	typedef enum logic [1:0] {
		INT_UNIT,
		BRANCH_UNIT,
		MULT_UNIT
	} ex_unit_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLT,
		ALU_SLTU,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA
	} alu_func_e;

	typedef enum logic [1:0] {
		OPA_IS_RS1,
		OPA_IS_NPC,
		OPA_IS_PC,
		OPA_IS_ZERO
	} opa_select_e;

	typedef enum logic [2:0] {
		OPB_IS_RS2,
		OPB_IS_I_IMM,
		OPB_IS_S_IMM,
		OPB_IS_B_IMM,
		OPB_IS_U_IMM,
		OPB_IS_J_IMM
	} opb_select_e;

endpackage

`default_nettype wire

// File: common/ex_op_if.sv
// decoded op from operand_decode to the integer and multiply paths
// at most one of int_valid and mult_valid is high in a cycle
`default_nettype none
`timescale 1ns/10ps

interface ex_op_if;
	import rv32_pkg::*;
	import ex_pkg::*;

	logic                int_valid;	// integer or branch class
	logic                mult_valid;
	logic [XLEN-1:0]     opa;
	logic [XLEN-1:0]     opb;
	logic [XLEN-1:0]     rs1;	// raw values for compare and multiply
	logic [XLEN-1:0]     rs2;
	alu_func_e           alu_func;
	branch_funct_e       branch_funct;
	mult_funct_e         mult_funct;
	logic                cond_branch;
	logic                uncond_branch;
	logic [XLEN-1:0]     npc;	// link value of a jump
	logic [TAG_BITS-1:0] dest_tag;

	modport decode (output int_valid, mult_valid, opa, opb, rs1, rs2, alu_func,
		branch_funct, mult_funct, cond_branch, uncond_branch, npc, dest_tag);
	modport int_unit (input int_valid, opa, opb, rs1, rs2, alu_func, branch_funct,
		cond_branch, uncond_branch, npc, dest_tag);
	modport mult_unit (input mult_valid, rs1, rs2, mult_funct, dest_tag);

endinterface

`default_nettype wire

// File: common/complete_if.sv
// one finished result from an execution unit to the completion queue
// no ready, the queue takes the result in every cycle valid is high
`default_nettype none
`timescale 1ns/10ps

interface complete_if;
	import rv32_pkg::*;
	import ex_pkg::*;

	logic                valid;
	logic [TAG_BITS-1:0] dest_tag;
	logic [XLEN-1:0]     result;
	logic                take_branch;
	logic [XLEN-1:0]     target;	// branch or jump destination

	modport source (output valid, dest_tag, result, take_branch, target);
	modport sink (input valid, dest_tag, result, take_branch, target);

endinterface

`default_nettype wire

// File: rtl/operand_decode.sv
// operand selection and routing for the execute stage, combinational
// picks opa/opb, extracts immediates from the instruction word views
`default_nettype none
`timescale 1ns/10ps

module operand_decode (
	input  wire                        issue_valid,
	input  wire rv32_pkg::rv32_inst_t  issue_inst,
	input  wire [rv32_pkg::XLEN-1:0]   issue_pc,
	input  wire [rv32_pkg::XLEN-1:0]   issue_npc,
	input  wire [rv32_pkg::XLEN-1:0]   issue_rs1_value,
	input  wire [rv32_pkg::XLEN-1:0]   issue_rs2_value,
	input  wire ex_pkg::ex_unit_e      issue_unit,
	input  wire ex_pkg::alu_func_e     issue_alu_func,
	input  wire ex_pkg::opa_select_e   issue_opa_select,
	input  wire ex_pkg::opb_select_e   issue_opb_select,
	input  wire                        issue_cond_branch,
	input  wire                        issue_uncond_branch,
	input  wire [ex_pkg::TAG_BITS-1:0] issue_dest_tag,
	ex_op_if.decode                    op
);
	import rv32_pkg::*;
	import ex_pkg::*;

	logic [XLEN-1:0] i_imm;
	logic [XLEN-1:0] s_imm;
	logic [XLEN-1:0] b_imm;
	logic [XLEN-1:0] u_imm;
	logic [XLEN-1:0] j_imm;

	// sign-extended immediates
	assign i_imm = {{20{issue_inst.i.imm[11]}}, issue_inst.i.imm};
	assign s_imm = {{20{issue_inst.s.imm_hi[6]}}, issue_inst.s.imm_hi, issue_inst.s.imm_lo};
	assign b_imm = {{20{issue_inst.b.imm12}}, issue_inst.b.imm11, issue_inst.b.imm10_5,
		issue_inst.b.imm4_1, 1'b0};
	assign u_imm = {issue_inst.u.imm, 12'b0};
	assign j_imm = {{12{issue_inst.j.imm20}}, issue_inst.j.imm19_12, issue_inst.j.imm11,
		issue_inst.j.imm10_1, 1'b0};

	always_comb begin
		case (issue_opa_select)
			OPA_IS_RS1: op.opa = issue_rs1_value;
			OPA_IS_NPC: op.opa = issue_npc;
			OPA_IS_PC:  op.opa = issue_pc;
			default:    op.opa = '0;	// OPA_IS_ZERO
		endcase
	end

	always_comb begin
		case (issue_opb_select)
			OPB_IS_RS2:   op.opb = issue_rs2_value;
			OPB_IS_I_IMM: op.opb = i_imm;
			OPB_IS_S_IMM: op.opb = s_imm;
			OPB_IS_B_IMM: op.opb = b_imm;
			OPB_IS_U_IMM: op.opb = u_imm;
			OPB_IS_J_IMM: op.opb = j_imm;
			default:      op.opb = '0;
		endcase
	end

	// branches share the integer path
	assign op.int_valid = issue_valid && (issue_unit == INT_UNIT || issue_unit == BRANCH_UNIT);
	assign op.mult_valid = issue_valid && (issue_unit == MULT_UNIT);

	assign op.rs1           = issue_rs1_value;
	assign op.rs2           = issue_rs2_value;
	assign op.alu_func      = issue_alu_func;
	assign op.branch_funct  = branch_funct_e'(issue_inst.b.funct3);
	assign op.mult_funct    = mult_funct_e'(issue_inst.r.funct3);
	assign op.cond_branch   = issue_cond_branch;
	assign op.uncond_branch = issue_uncond_branch;
	assign op.npc           = issue_npc;
	assign op.dest_tag      = issue_dest_tag;

endmodule

`default_nettype wire

// File: rtl/execute/int_execute.sv
// integer path, combinational: ALU, branch condition and target adder
// result goes to the completion queue in the issue cycle
`default_nettype none
`timescale 1ns/10ps

module int_execute (
	ex_op_if.int_unit  op,
	complete_if.source res
);
	import rv32_pkg::*;
	import ex_pkg::*;

	logic signed [XLEN-1:0] s_opa;
	logic signed [XLEN-1:0] s_opb;
	logic signed [XLEN-1:0] s_rs1;
	logic signed [XLEN-1:0] s_rs2;
	logic [XLEN-1:0]        sum;
	logic [XLEN-1:0]        alu_result;
	logic                   cond;

	assign s_opa = op.opa;
	assign s_opb = op.opb;
	assign s_rs1 = op.rs1;
	assign s_rs2 = op.rs2;
	assign sum   = op.opa + op.opb;	// also the branch/jump target

	////////////////////////////////////////
	// ALU
	////////////////////////////////////////
	always_comb begin
		case (op.alu_func)
			ALU_ADD:  alu_result = sum;
			ALU_SUB:  alu_result = op.opa - op.opb;
			ALU_SLT:  alu_result = {{(XLEN-1){1'b0}}, s_opa < s_opb};
			ALU_SLTU: alu_result = {{(XLEN-1){1'b0}}, op.opa < op.opb};
			ALU_AND:  alu_result = op.opa & op.opb;
			ALU_OR:   alu_result = op.opa | op.opb;
			ALU_XOR:  alu_result = op.opa ^ op.opb;
			ALU_SLL:  alu_result = op.opa << op.opb[4:0];
			ALU_SRL:  alu_result = op.opa >> op.opb[4:0];
			ALU_SRA:  alu_result = s_opa >>> op.opb[4:0];	// keeps the sign
			default:  alu_result = '0;
		endcase
	end

	////////////////////////////////////////
	// branch condition on the raw registers
	////////////////////////////////////////
	always_comb begin
		case (op.branch_funct)
			BEQ:     cond = (op.rs1 == op.rs2);
			BNE:     cond = (op.rs1 != op.rs2);
			BLT:     cond = (s_rs1 < s_rs2);
			BGE:     cond = (s_rs1 >= s_rs2);
			BLTU:    cond = (op.rs1 < op.rs2);
			BGEU:    cond = (op.rs1 >= op.rs2);
			default: cond = 1'b0;
		endcase
	end

	assign res.valid       = op.int_valid;
	assign res.dest_tag    = op.dest_tag;
	assign res.take_branch = op.uncond_branch || (op.cond_branch && cond);
	assign res.target      = sum;

	// jumps write the link value, conditional branches write nothing useful
	always_comb begin
		if (op.uncond_branch) begin
			res.result = op.npc;
		end else if (op.cond_branch) begin
			res.result = '0;
		end else begin
			res.result = alu_result;
		end
	end

endmodule

`default_nettype wire

// File: rtl/execute/pipelined_multiplier.sv
// pipelined 32x32 multiplier for mul, mulh, mulhsu and mulhu
// one partial product per stage, accepts an op every cycle
// result leaves exactly MULT_STAGES cycles after issue
`default_nettype none
`timescale 1ns/10ps

module pipelined_multiplier #(
	parameter int MULT_STAGES = 4
) (
	input  wire        clock,
	input  wire        reset,
	input  wire        flush,
	ex_op_if.mult_unit op,
	complete_if.source res
);
	import rv32_pkg::*;
	import ex_pkg::*;

	localparam int STEP = 2 * XLEN / MULT_STAGES;	// multiplier bits per stage

	logic a_signed;
	logic b_signed;

	// index 0 is the issue side, index s the register behind stage s
	logic [2*XLEN-1:0]   mcand   [MULT_STAGES];
	logic [2*XLEN-1:0]   mplier  [MULT_STAGES];
	logic [2*XLEN-1:0]   product [MULT_STAGES+1];
	logic                valid   [MULT_STAGES+1];
	logic [TAG_BITS-1:0] tag     [MULT_STAGES+1];
	mult_funct_e         func    [MULT_STAGES+1];

	// mulhsu: rs1 signed, rs2 unsigned
	assign a_signed = (op.mult_funct != MULHU);
	assign b_signed = (op.mult_funct == MUL) || (op.mult_funct == MULH);

	assign mcand[0]   = {{XLEN{a_signed & op.rs1[XLEN-1]}}, op.rs1};
	assign mplier[0]  = {{XLEN{b_signed & op.rs2[XLEN-1]}}, op.rs2};
	assign product[0] = '0;
	assign valid[0]   = op.mult_valid;
	assign tag[0]     = op.dest_tag;
	assign func[0]    = op.mult_funct;

	for (genvar s = 1; s <= MULT_STAGES; s++) begin : stage
		always_ff @(posedge clock) begin
			product[s] <= product[s-1]
				+ (2*XLEN)'(mplier[s-1][STEP-1:0]) * mcand[s-1];
			tag[s]     <= tag[s-1];
			func[s]    <= func[s-1];
		end

		always_ff @(posedge clock) begin
			if (reset || flush) begin
				valid[s] <= 1'b0;	// cancels in-flight ops
			end else begin
				valid[s] <= valid[s-1];
			end
		end

		// last stage has nothing left to shift
		if (s < MULT_STAGES) begin : shift
			always_ff @(posedge clock) begin
				mcand[s]  <= mcand[s-1] << STEP;
				mplier[s] <= mplier[s-1] >> STEP;
			end
		end
	end

	assign res.valid       = valid[MULT_STAGES];
	assign res.dest_tag    = tag[MULT_STAGES];
	assign res.result      = (func[MULT_STAGES] == MUL) ? product[MULT_STAGES][XLEN-1:0]
		: product[MULT_STAGES][2*XLEN-1:XLEN];	// high word for the mulh forms
	assign res.take_branch = 1'b0;
	assign res.target      = '0;

endmodule

`default_nettype wire

// File: rtl/complete_queue.sv
// in-order completion queue, two write ports and one read port
// multiplier entry is written ahead of the integer entry in a cycle
// head entry is presented from registers, flush empties the queue
`default_nettype none
`timescale 1ns/10ps

module complete_queue #(
	parameter int MULT_STAGES = 4,
	parameter int QUEUE_DEPTH = MULT_STAGES + 2
) (
	input  wire                         clock,
	input  wire                         reset,
	input  wire                         flush,
	complete_if.sink                    mult_in,
	complete_if.sink                    int_in,
	output logic                        complete_valid,
	output logic [ex_pkg::TAG_BITS-1:0] complete_dest_tag,
	output logic                        reg_wr_en,
	output logic [rv32_pkg::XLEN-1:0]   ex_result,
	output logic                        take_branch,
	output logic [rv32_pkg::XLEN-1:0]   branch_target
);
	import rv32_pkg::*;
	import ex_pkg::*;

	// backlog grows by one per collision, at most one per multiply in flight
	localparam int DEPTH = (QUEUE_DEPTH > MULT_STAGES + 1) ? QUEUE_DEPTH : MULT_STAGES + 2;
	localparam int PTR_BITS = $clog2(DEPTH);
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	logic [TAG_BITS-1:0] tag_q    [DEPTH];
	logic [XLEN-1:0]     result_q [DEPTH];
	logic                branch_q [DEPTH];
	logic [XLEN-1:0]     target_q [DEPTH];

	logic [PTR_BITS-1:0] head;
	logic [PTR_BITS-1:0] tail;
	logic [PTR_BITS-1:0] tail_plus1;
	logic [PTR_BITS-1:0] int_slot;
	logic [CNT_BITS-1:0] count;
	logic [CNT_BITS-1:0] n_wr;
	logic [CNT_BITS-1:0] n_pop;

	function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] p);
		return (p == PTR_BITS'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign tail_plus1 = next_ptr(tail);
	assign int_slot   = mult_in.valid ? tail_plus1 : tail;	// behind the multiply
	assign n_wr       = CNT_BITS'(mult_in.valid) + CNT_BITS'(int_in.valid);
	assign n_pop      = CNT_BITS'(complete_valid);

	////////////////////////////////////////
	// entry storage
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (mult_in.valid) begin
			tag_q[tail]    <= mult_in.dest_tag;
			result_q[tail] <= mult_in.result;
			branch_q[tail] <= mult_in.take_branch;
			target_q[tail] <= mult_in.target;
		end
		if (int_in.valid) begin
			tag_q[int_slot]    <= int_in.dest_tag;
			result_q[int_slot] <= int_in.result;
			branch_q[int_slot] <= int_in.take_branch;
			target_q[int_slot] <= int_in.target;
		end
	end

	// pointers and occupancy
	always_ff @(posedge clock) begin
		if (reset || flush) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (complete_valid) begin
				head <= next_ptr(head);	// one pop per cycle
			end
			if (mult_in.valid && int_in.valid) begin
				tail <= next_ptr(tail_plus1);
			end else if (mult_in.valid || int_in.valid) begin
				tail <= tail_plus1;
			end
			count <= count + n_wr - n_pop;
		end
	end

	assign complete_valid    = (count != '0);
	assign complete_dest_tag = tag_q[head];
	assign reg_wr_en         = complete_valid && (tag_q[head] != '0);	// tag 0 writes nothing
	assign ex_result         = result_q[head];
	assign take_branch       = complete_valid && branch_q[head];
	assign branch_target     = target_q[head];

endmodule

`default_nettype wire

// File: rtl/ex_stage.sv
// execute stage of a single-issue RV32 core
// one issued op per cycle in, one completed result per cycle out
// multiplies take MULT_STAGES cycles, everything else completes at once
`default_nettype none
`timescale 1ns/10ps

module ex_stage #(
	parameter int MULT_STAGES = 4,
	parameter int QUEUE_DEPTH = MULT_STAGES + 2
) (
	input  wire                          clock,
	input  wire                          reset,
	input  wire                          flush,
	input  wire                          issue_valid,
	input  wire rv32_pkg::rv32_inst_t    issue_inst,
	input  wire [rv32_pkg::XLEN-1:0]     issue_pc,
	input  wire [rv32_pkg::XLEN-1:0]     issue_npc,
	input  wire [rv32_pkg::XLEN-1:0]     issue_rs1_value,
	input  wire [rv32_pkg::XLEN-1:0]     issue_rs2_value,
	input  wire ex_pkg::ex_unit_e        issue_unit,
	input  wire ex_pkg::alu_func_e       issue_alu_func,
	input  wire ex_pkg::opa_select_e     issue_opa_select,
	input  wire ex_pkg::opb_select_e     issue_opb_select,
	input  wire                          issue_cond_branch,
	input  wire                          issue_uncond_branch,
	input  wire [ex_pkg::TAG_BITS-1:0]   issue_dest_tag,
	output logic                         complete_valid,
	output logic [ex_pkg::TAG_BITS-1:0]  complete_dest_tag,
	output logic                         reg_wr_en,
	output logic [rv32_pkg::XLEN-1:0]    ex_result,
	output logic                         take_branch,
	output logic [rv32_pkg::XLEN-1:0]    branch_target
);

	ex_op_if    op ();
	complete_if int_res ();
	complete_if mult_res ();

	operand_decode decode0 (
		.issue_valid         (issue_valid),
		.issue_inst          (issue_inst),
		.issue_pc            (issue_pc),
		.issue_npc           (issue_npc),
		.issue_rs1_value     (issue_rs1_value),
		.issue_rs2_value     (issue_rs2_value),
		.issue_unit          (issue_unit),
		.issue_alu_func      (issue_alu_func),
		.issue_opa_select    (issue_opa_select),
		.issue_opb_select    (issue_opb_select),
		.issue_cond_branch   (issue_cond_branch),
		.issue_uncond_branch (issue_uncond_branch),
		.issue_dest_tag      (issue_dest_tag),
		.op                  (op.decode)
	);

	int_execute int_ex0 (
		.op  (op.int_unit),
		.res (int_res.source)
	);

	pipelined_multiplier #(.MULT_STAGES(MULT_STAGES)) mult0 (
		.clock (clock),
		.reset (reset),
		.flush (flush),
		.op    (op.mult_unit),
		.res   (mult_res.source)
	);

	complete_queue #(
		.MULT_STAGES (MULT_STAGES),
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) queue0 (
		.clock             (clock),
		.reset             (reset),
		.flush             (flush),
		.mult_in           (mult_res.sink),
		.int_in            (int_res.sink),
		.complete_valid    (complete_valid),
		.complete_dest_tag (complete_dest_tag),
		.reg_wr_en         (reg_wr_en),
		.ex_result         (ex_result),
		.take_branch       (take_branch),
		.branch_target     (branch_target)
	);

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
// clock and reset source for the execute stage testbench
// free-running clock, reset held high for the first RESET_CYCLES edges
`default_nettype none
`timescale 1ns/10ps

module tb_clock_gen #(
	parameter int PERIOD       = 100,	// ns
	parameter int RESET_CYCLES = 8
) (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	// release on a falling edge, away from the sampling edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

// File: verif/ex_stage_tb.sv
// testbench for the execute stage
// drives directed and random ops on the falling edge, models the expected
// completion stream cycle by cycle and checks every output beat against it
`default_nettype none
`timescale 1ns/10ps

module ex_stage_tb;
	import rv32_pkg::*;
	import ex_pkg::*;

	localparam int MULT_STAGES = 4;
	localparam int RESET_LIMIT = 32;	// cycles
	localparam int DRAIN_LIMIT = 64;

	typedef struct packed {
		logic [TAG_BITS-1:0] tag;
		logic [XLEN-1:0]     result;
		logic                take;
		logic [XLEN-1:0]     target;
	} exp_t;

	logic                clock;
	logic                reset;
	logic                flush;
	logic                issue_valid;
	rv32_inst_t          issue_inst;
	logic [XLEN-1:0]     issue_pc;
	logic [XLEN-1:0]     issue_npc;
	logic [XLEN-1:0]     issue_rs1_value;
	logic [XLEN-1:0]     issue_rs2_value;
	ex_unit_e            issue_unit;
	alu_func_e           issue_alu_func;
	opa_select_e         issue_opa_select;
	opb_select_e         issue_opb_select;
	logic                issue_cond_branch;
	logic                issue_uncond_branch;
	logic [TAG_BITS-1:0] issue_dest_tag;
	logic                complete_valid;
	logic [TAG_BITS-1:0] complete_dest_tag;
	logic                reg_wr_en;
	logic [XLEN-1:0]     ex_result;
	logic                take_branch;
	logic [XLEN-1:0]     branch_target;

	int   seed = 35;
	int   value_errors = 0;
	int   timeout_errors = 0;
	int   checked = 0;
	logic active = 1'b0;	// out of reset, as seen at a rising edge
	logic seen_issue = 1'b0;
	exp_t exp_q[$];	// expected beats in queue order
	exp_t mpipe[MULT_STAGES];
	logic mvalid[MULT_STAGES];

	tb_clock_gen #(.PERIOD(100), .RESET_CYCLES(8)) clock_gen0 (
		.clock (clock),
		.reset (reset)
	);

	ex_stage #(.MULT_STAGES(MULT_STAGES)) dut (
		.clock               (clock),
		.reset               (reset),
		.flush               (flush),
		.issue_valid         (issue_valid),
		.issue_inst          (issue_inst),
		.issue_pc            (issue_pc),
		.issue_npc           (issue_npc),
		.issue_rs1_value     (issue_rs1_value),
		.issue_rs2_value     (issue_rs2_value),
		.issue_unit          (issue_unit),
		.issue_alu_func      (issue_alu_func),
		.issue_opa_select    (issue_opa_select),
		.issue_opb_select    (issue_opb_select),
		.issue_cond_branch   (issue_cond_branch),
		.issue_uncond_branch (issue_uncond_branch),
		.issue_dest_tag      (issue_dest_tag),
		.complete_valid      (complete_valid),
		.complete_dest_tag   (complete_dest_tag),
		.reg_wr_en           (reg_wr_en),
		.ex_result           (ex_result),
		.take_branch         (take_branch),
		.branch_target       (branch_target)
	);

	////////////////////////////////////////
	// reference functions
	////////////////////////////////////////
	function automatic logic [31:0] opb_ref(input opb_select_e sel, input logic [31:0] w,
		input logic [31:0] rs2);
		case (sel)
			OPB_IS_RS2:   return rs2;
			OPB_IS_I_IMM: return {{20{w[31]}}, w[31:20]};
			OPB_IS_S_IMM: return {{20{w[31]}}, w[31:25], w[11:7]};
			OPB_IS_B_IMM: return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			OPB_IS_U_IMM: return {w[31:12], 12'b0};
			OPB_IS_J_IMM: return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			default:      return '0;
		endcase
	endfunction

	function automatic logic [31:0] alu_ref(input alu_func_e f, input logic [31:0] a,
		input logic [31:0] b);
		case (f)
			ALU_ADD:  return a + b;
			ALU_SUB:  return a - b;
			ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
			ALU_SLTU: return {31'b0, a < b};
			ALU_AND:  return a & b;
			ALU_OR:   return a | b;
			ALU_XOR:  return a ^ b;
			ALU_SLL:  return a << b[4:0];
			ALU_SRL:  return a >> b[4:0];
			ALU_SRA:  return $signed(a) >>> b[4:0];
			default:  return '0;
		endcase
	endfunction

	function automatic logic branch_ref(input logic [2:0] f, input logic [31:0] a,
		input logic [31:0] b);
		case (f)
			BEQ:     return a == b;
			BNE:     return a != b;
			BLT:     return $signed(a) < $signed(b);
			BGE:     return $signed(a) >= $signed(b);
			BLTU:    return a < b;
			BGEU:    return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	// full 64-bit product, high word for the mulh forms
	function automatic logic [31:0] mult_ref(input logic [2:0] f, input logic [31:0] a,
		input logic [31:0] b);
		logic [63:0] ea;
		logic [63:0] eb;
		logic [63:0] p;
		ea = (f == MULHU) ? {32'b0, a} : {{32{a[31]}}, a};
		eb = (f == MUL || f == MULH) ? {{32{b[31]}}, b} : {32'b0, b};
		p  = ea * eb;
		return (f == MUL) ? p[31:0] : p[63:32];
	endfunction

	function automatic logic [31:0] rand_word();
		return $random(seed);
	endfunction

	function automatic logic [TAG_BITS-1:0] rand_tag();
		return TAG_BITS'(rand_word());
	endfunction

	function automatic logic [31:0] corner(input int k);
		case (k)
			0:       return 32'h8000_0000;	// most negative
			1:       return 32'hffff_ffff;
			2:       return 32'h0000_0000;
			3:       return 32'h7fff_ffff;
			default: return rand_word();
		endcase
	endfunction

	////////////////////////////////////////
	// model, updated at each rising edge
	////////////////////////////////////////
	always @(posedge clock) begin : model
		exp_t        e;
		logic [31:0] opa;
		logic [31:0] opb;
		if (reset || flush) begin
			exp_q.delete();
			for (int s = 0; s < MULT_STAGES; s++) mvalid[s] = 1'b0;
			active = !reset;
		end else begin
			active = 1'b1;
			if (mvalid[MULT_STAGES-1]) exp_q.push_back(mpipe[MULT_STAGES-1]);	// ahead of int
			if (issue_valid && issue_unit != MULT_UNIT) begin
				case (issue_opa_select)
					OPA_IS_RS1: opa = issue_rs1_value;
					OPA_IS_NPC: opa = issue_npc;
					OPA_IS_PC:  opa = issue_pc;
					default:    opa = '0;
				endcase
				opb = opb_ref(issue_opb_select, issue_inst, issue_rs2_value);
				e.tag    = issue_dest_tag;
				e.target = opa + opb;
				e.take   = issue_uncond_branch ||
					(issue_cond_branch && branch_ref(issue_inst[14:12], issue_rs1_value,
					issue_rs2_value));
				if (issue_uncond_branch) e.result = issue_npc;
				else if (issue_cond_branch) e.result = '0;
				else e.result = alu_ref(issue_alu_func, opa, opb);
				exp_q.push_back(e);
			end
			for (int s = MULT_STAGES - 1; s > 0; s--) begin
				mvalid[s] = mvalid[s-1];
				mpipe[s]  = mpipe[s-1];
			end
			mvalid[0] = issue_valid && (issue_unit == MULT_UNIT);
			mpipe[0]  = '{issue_dest_tag,
				mult_ref(issue_inst[14:12], issue_rs1_value, issue_rs2_value), 1'b0, '0};
			if (issue_valid) seen_issue = 1'b1;
		end
	end

	////////////////////////////////////////
	// checks
	////////////////////////////////////////
	always @(negedge clock) begin : check_outputs
		exp_t e;
		if (active) begin
			if (!seen_issue) begin
				assert (!complete_valid && !reg_wr_en && !take_branch) else begin
					value_errors++;
					$display("FAIL complete_valid/reg_wr_en/take_branch: got %h/%h/%h %s",
						complete_valid, reg_wr_en, take_branch,
						"expected 0/0/0 before the first issue");
				end
			end
			// exact cycle of every beat
			assert (complete_valid == (exp_q.size() != 0)) else begin
				value_errors++;
				$display("FAIL complete_valid: got %h expected %h", complete_valid,
					exp_q.size() != 0);
			end
			if (complete_valid && exp_q.size() != 0) begin
				e = exp_q.pop_front();
				checked++;
				assert (complete_dest_tag == e.tag) else begin
					value_errors++;
					$display("FAIL complete_dest_tag: got %h expected %h", complete_dest_tag,
						e.tag);
				end
				assert (ex_result == e.result) else begin
					value_errors++;
					$display("FAIL ex_result: got %h expected %h", ex_result, e.result);
				end
				assert (reg_wr_en == (e.tag != '0)) else begin
					value_errors++;
					$display("FAIL reg_wr_en: got %h expected %h", reg_wr_en, e.tag != '0);
				end
				assert (take_branch == e.take) else begin
					value_errors++;
					$display("FAIL take_branch: got %h expected %h", take_branch, e.take);
				end
				if (e.take) begin
					assert (branch_target == e.target) else begin
						value_errors++;
						$display("FAIL branch_target: got %h expected %h", branch_target,
							e.target);
					end
				end
			end
		end
	end

	// no register write without a result
	assert property (@(posedge clock) disable iff (reset) !complete_valid |-> !reg_wr_en)
		else begin
		value_errors++;
		$display("FAIL reg_wr_en: got %h expected 0 with no valid result",
			$sampled(reg_wr_en));
	end

	assert property (@(posedge clock) disable iff (reset) take_branch |-> complete_valid)
		else begin
		value_errors++;
		$display("FAIL take_branch: got %h expected 0 with no valid result",
			$sampled(take_branch));
	end

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////
	task automatic issue_op(input ex_unit_e unit, input alu_func_e func,
		input opa_select_e asel, input opb_select_e bsel, input logic cond,
		input logic uncond, input logic [31:0] word, input logic [31:0] a,
		input logic [31:0] b, input logic [TAG_BITS-1:0] tag);
		@(negedge clock);
		issue_valid         = 1'b1;
		issue_unit          = unit;
		issue_alu_func      = func;
		issue_opa_select    = asel;
		issue_opb_select    = bsel;
		issue_cond_branch   = cond;
		issue_uncond_branch = uncond;
		issue_inst          = rv32_inst_t'(word);
		issue_pc            = rand_word() & 32'hffff_fffc;
		issue_npc           = issue_pc + 32'd4;
		issue_rs1_value     = a;
		issue_rs2_value     = b;
		issue_dest_tag      = tag;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clock);
			issue_valid = 1'b0;
		end
	endtask

	task automatic random_op(input int unit_sel);
		logic [31:0] word;
		logic        jump;
		word = rand_word();
		jump = rand_word() % 4 == 0;
		case (unit_sel)
			0: issue_op(INT_UNIT, alu_func_e'(4'(rand_word() % 10)),
				opa_select_e'(2'(rand_word())), opb_select_e'(3'(rand_word() % 6)),
				1'b0, 1'b0, word, rand_word(), rand_word(), rand_tag());
			1: issue_op(BRANCH_UNIT, ALU_ADD, OPA_IS_PC, jump ? OPB_IS_J_IMM : OPB_IS_B_IMM,
				!jump, jump, word, corner(rand_word() % 6), corner(rand_word() % 6),
				jump ? rand_tag() : '0);
			default: issue_op(MULT_UNIT, ALU_ADD, OPA_IS_RS1, OPB_IS_RS2, 1'b0, 1'b0,
				{word[31:15], 1'b0, word[13:0]}, corner(rand_word() % 8),
				corner(rand_word() % 8), rand_tag());
		endcase
	endtask

	// flush cycle repeats the last op, which must be dropped
	task automatic pulse_flush();
		@(negedge clock);
		flush       = 1'b1;
		issue_valid = 1'b1;
		@(negedge clock);
		flush       = 1'b0;
		issue_valid = 1'b0;
	endtask

	task automatic drain();
		int n;
		n = 0;
		idle(1);
		while ((exp_q.size() != 0 || n < MULT_STAGES) && n < DRAIN_LIMIT) begin
			@(negedge clock);
			#1;
			n++;
		end
		if (exp_q.size() != 0) begin
			timeout_errors++;
			$display("timed out with %0d results still missing", exp_q.size());
		end
	endtask

	initial begin : main
		logic [2:0]  bcodes[6];
		logic [31:0] lhs[5];
		logic [31:0] rhs[5];
		logic [31:0] word;
		int          n;
		bcodes = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};
		lhs    = '{32'd5, 32'd3, 32'd7, 32'hffff_ffff, 32'd1};	// eq, lt, gt, sign flips
		rhs    = '{32'd5, 32'd7, 32'd3, 32'd1, 32'hffff_ffff};
		flush               = 1'b0;
		issue_valid         = 1'b0;
		issue_inst          = '0;
		issue_pc            = '0;
		issue_npc           = '0;
		issue_rs1_value     = '0;
		issue_rs2_value     = '0;
		issue_unit          = INT_UNIT;
		issue_alu_func      = ALU_ADD;
		issue_opa_select    = OPA_IS_RS1;
		issue_opb_select    = OPB_IS_RS2;
		issue_cond_branch   = 1'b0;
		issue_uncond_branch = 1'b0;
		issue_dest_tag      = '0;
		n = 0;
		while (reset !== 1'b0 && n < RESET_LIMIT) begin
			@(posedge clock);
			n++;
		end
		if (reset !== 1'b0) begin
			timeout_errors++;
			$display("reset was never released");
		end
		idle(6);	// quiet after reset

		// every ALU function with every operand select, tag 0 on the zero/rs2 pair
		for (int f = 0; f < 10; f++)
			for (int a = 0; a < 4; a++)
				for (int b = 0; b < 6; b++)
					issue_op(INT_UNIT, alu_func_e'(4'(f)), opa_select_e'(2'(a)),
						opb_select_e'(3'(b)), 1'b0, 1'b0, rand_word(), rand_word(),
						rand_word(), (a == 3 && b == 0) ? '0 : rand_tag());
		drain();

		// branches on equal, less and greater operands, then jumps
		for (int f = 0; f < 6; f++)
			for (int k = 0; k < 5; k++) begin
				word = rand_word();
				word[14:12] = bcodes[f];
				issue_op(BRANCH_UNIT, ALU_ADD, OPA_IS_PC, OPB_IS_B_IMM, 1'b1, 1'b0, word,
					lhs[k], rhs[k], '0);
			end
		for (int k = 0; k < 8; k++)
			issue_op(BRANCH_UNIT, ALU_ADD, k[0] ? OPA_IS_RS1 : OPA_IS_PC,
				k[0] ? OPB_IS_I_IMM : OPB_IS_J_IMM, 1'b0, 1'b1, rand_word(), rand_word(),
				rand_word(), rand_tag());
		drain();

		// back-to-back multiplies over corner operands
		for (int f = 0; f < 4; f++)
			for (int a = 0; a < 5; a++)
				for (int b = 0; b < 5; b++) begin
					word = rand_word();
					word[14:12] = 3'(f);
					issue_op(MULT_UNIT, ALU_ADD, OPA_IS_RS1, OPB_IS_RS2, 1'b0, 1'b0, word,
						corner(a), corner(b), rand_tag());
				end
		drain();

		// integer op lands in the same write cycle as the multiply
		for (int k = 0; k < 4; k++) begin
			random_op(2);
			idle(MULT_STAGES - 1);
			random_op(0);
		end
		drain();

		// dense mixed stream
		for (int k = 0; k < 400; k++) random_op(rand_word() % 3);
		drain();

		// flush with a backlog queued and multiplies in flight
		for (int k = 0; k < 3; k++) random_op(2);
		for (int k = 0; k < 3; k++) random_op(0);
		random_op(2);
		random_op(2);
		pulse_flush();
		idle(MULT_STAGES + 4);
		for (int k = 0; k < 40; k++) random_op(rand_word() % 3);
		drain();

		$display("errors: %0d value, %0d timeout, %0d results checked", value_errors,
			timeout_errors, checked);
		if (value_errors == 0 && timeout_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
common/rv32_pkg.sv
common/ex_pkg.sv
common/ex_op_if.sv
common/complete_if.sv
rtl/operand_decode.sv
rtl/execute/int_execute.sv
rtl/execute/pipelined_multiplier.sv
rtl/complete_queue.sv
rtl/ex_stage.sv
verif/tb_clock_gen.sv
verif/ex_stage_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = ex_stage_tb
FILELIST  = compile.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
